//--- fp_compare_unit.f
rtl/fp_cmp_pkg.sv
rtl/fp_classifier.sv
rtl/fp_comparator.sv
rtl/fp_compare_unit.sv
tests/tb_fp_compare_unit.sv

//--- Bender.yml
package:
  name: fp_compare_unit

dependencies: {}

sources:
  - files:
      - rtl/fp_cmp_pkg.sv
      - rtl/fp_classifier.sv
      - rtl/fp_comparator.sv
      - rtl/fp_compare_unit.sv

  - target: test
    files:
      - tests/tb_fp_compare_unit.sv

//--- tests/tb_fp_compare_unit.sv
// Single precision only (default parameters); apart from the burst, operations are issued and checked one at a time
`timescale 1ns/1ps
`default_nettype none

module tb_fp_compare_unit
    import fp_cmp_pkg::*;
;
    localparam int CLK_PERIOD      = 40;
    localparam int N_RANDOM        = 200;
    localparam int N_MINMAX_RANDOM = 20;
    localparam int N_BURST         = 8;
    localparam int NUM_OPS = 48 + 3 * N_RANDOM + 7 + 12 + 2 * N_MINMAX_RANDOM + 10 + N_BURST;
    localparam int WATCHDOG_CYCLES = 2 * NUM_OPS + 20;    // Single ops take two cycles each
    localparam logic [31:0] QNAN = 32'h7fc0_0000;
    localparam logic [31:0] SNAN = 32'h7f80_0001;
    localparam logic [31:0] ONE  = 32'h3f80_0000;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        op_valid = 1'b0;
    fp_cmd_t     cmd = FP_CMD_EQ;
    logic [31:0] src1 = '0;
    logic [31:0] src2 = '0;
    logic        res_valid;
    word_t       int_result;
    logic [31:0] fp_result;
    fflags_t     fflags;

    logic [31:0] rng_state = 32'h7905;
    int          checks = 0;
    int          errors = 0;
    int          errors_at_start = 0;

    fp_compare_unit #(
        .EXPONENT_WIDTH (8),
        .FRACTION_WIDTH (23)
    ) i_fp_compare_unit (
        .clk        (clk),
        .arst_n     (arst_n),
        .op_valid   (op_valid),
        .cmd        (cmd),
        .src1       (src1),
        .src2       (src2),
        .res_valid  (res_valid),
        .int_result (int_result),
        .fp_result  (fp_result),
        .fflags     (fflags)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Run did not finish within %0d cycles, aborting", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Random operand with the all-ones exponent avoided
    function automatic logic [31:0] rand_number();
        logic [31:0] x;
        x = next_rand();
        if (x[30:23] == 8'hff) begin
            x[23] = 1'b0;
        end
        return x;
    endfunction

    function automatic logic is_nan(logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != '0);
    endfunction

    function automatic logic is_snan(logic [31:0] x);
        return is_nan(x) && !x[22];
    endfunction

    function automatic logic is_zero(logic [31:0] x);
        return x[30:0] == '0;
    endfunction

    // Maps sign-magnitude onto an unsigned order
    function automatic logic [31:0] order_key(logic [31:0] x);
        return x[31] ? ~x : {1'b1, x[30:0]};
    endfunction

    function automatic logic ref_eq(logic [31:0] a, logic [31:0] b);
        return (a == b) || (is_zero(a) && is_zero(b));
    endfunction

    function automatic logic ref_lt(logic [31:0] a, logic [31:0] b);
        if (is_zero(a) && is_zero(b)) begin
            return 1'b0;
        end
        return order_key(a) < order_key(b);
    endfunction

    function automatic logic [9:0] ref_class(logic [31:0] x);
        logic [9:0] m;
        m = '0;
        if (is_nan(x)) m[x[22] ? CLASS_QNAN : CLASS_SNAN] = 1'b1;
        else if (x[30:23] == 8'hff) m[x[31] ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
        else if (is_zero(x)) m[x[31] ? CLASS_NEG_ZERO : CLASS_POS_ZERO] = 1'b1;
        else if (x[30:23] == 8'h00) m[x[31] ? CLASS_NEG_SUB : CLASS_POS_SUB] = 1'b1;
        else m[x[31] ? CLASS_NEG_NORM : CLASS_POS_NORM] = 1'b1;
        return m;
    endfunction

    function automatic logic [31:0] ref_minmax(logic is_max, logic [31:0] a, logic [31:0] b);
        logic a_first;
        if (is_nan(a) && is_nan(b)) return QNAN;
        if (is_nan(a)) return b;
        if (is_nan(b)) return a;
        if (is_zero(a) && is_zero(b)) a_first = (a[31] != is_max);    // -0 for min, +0 for max
        else a_first = ref_lt(a, b) != is_max;
        return a_first ? a : b;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_result(input fp_cmd_t c, input logic [31:0] a, input logic [31:0] b);
        logic [31:0] exp_int;
        fflags_t     exp_flags;
        logic        any_nan;
        any_nan = is_nan(a) || is_nan(b);
        exp_flags = '0;
        case (c)
            FP_CMD_EQ:    exp_int = {31'b0, !any_nan && ref_eq(a, b)};
            FP_CMD_LT:    exp_int = {31'b0, !any_nan && ref_lt(a, b)};
            FP_CMD_LE:    exp_int = {31'b0, !any_nan && (ref_eq(a, b) || ref_lt(a, b))};
            FP_CMD_CLASS: exp_int = {22'b0, ref_class(a)};
            default:      exp_int = ref_minmax(c == FP_CMD_MAX, a, b);
        endcase
        if (c == FP_CMD_LT || c == FP_CMD_LE) exp_flags[FFLAG_NV] = any_nan;
        else if (c != FP_CMD_CLASS) exp_flags[FFLAG_NV] = is_snan(a) || is_snan(b);
        check_val("res_valid", 32'd1, {31'b0, res_valid});
        if (c == FP_CMD_MIN || c == FP_CMD_MAX) check_val("fp_result", exp_int, fp_result);
        else check_val("int_result", exp_int, int_result);
        check_val("fflags", {27'b0, exp_flags}, {27'b0, fflags});
    endtask

    task automatic run_op(input fp_cmd_t c, input logic [31:0] a, input logic [31:0] b);
        @(negedge clk);
        op_valid = 1'b1;
        cmd = c;
        src1 = a;
        src2 = b;
        @(negedge clk);
        op_valid = 1'b0;
        check_result(c, a, b);
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic test_timing();
        fp_cmd_t     c[N_BURST];
        logic [31:0] a[N_BURST];
        logic [31:0] b[N_BURST];
        repeat (3) begin
            @(negedge clk);
            check_val("res_valid", 32'd0, {31'b0, res_valid});
            check_val("int_result", 32'd0, int_result);
            check_val("fp_result", 32'd0, fp_result);
            check_val("fflags", 32'd0, {27'b0, fflags});
        end
        for (int i = 0; i <= N_BURST; i++) begin
            @(negedge clk);
            if (i > 0) check_result(c[i-1], a[i-1], b[i-1]);
            if (i < N_BURST) begin
                c[i] = fp_cmd_t'(i % 6);
                a[i] = rand_number();
                b[i] = (i % 3 == 0) ? SNAN : rand_number();
                op_valid = 1'b1;
                cmd = c[i];
                src1 = a[i];
                src2 = b[i];
            end else begin
                op_valid = 1'b0;
            end
        end
        @(negedge clk);
        check_val("res_valid", 32'd0, {31'b0, res_valid});
        finish_test("timing and reset");
    endtask

    task automatic test_ordering();
        logic [31:0] pa[8] = '{ONE, ONE, 32'h4000_0000, 32'h3f80_0001, 32'hc000_0000,
                               32'h0000_0000, 32'h0000_0001, 32'h7f80_0000};
        logic [31:0] pb[8] = '{ONE, 32'hbf80_0000, ONE, ONE, 32'hbf80_0000,
                               32'h8000_0000, 32'h8000_0001, 32'h7f7f_ffff};
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 3; k++) begin
                run_op(fp_cmd_t'(k), pa[i], pb[i]);
                run_op(fp_cmd_t'(k), pb[i], pa[i]);
            end
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            a = rand_number();
            b = (i % 8 == 0) ? a : rand_number();    // Some equal pairs
            for (int k = 0; k < 3; k++) run_op(fp_cmd_t'(k), a, b);
        end
        finish_test("ordering");
    endtask

    task automatic test_nan_compare();
        run_op(FP_CMD_EQ, QNAN, ONE);
        run_op(FP_CMD_EQ, QNAN, QNAN);
        run_op(FP_CMD_EQ, ONE, SNAN);
        run_op(FP_CMD_LT, QNAN, ONE);
        run_op(FP_CMD_LT, ONE, SNAN);
        run_op(FP_CMD_LE, QNAN, ONE);
        run_op(FP_CMD_LE, SNAN, ONE);
        finish_test("nan compares");
    endtask

    task automatic test_min_max();
        for (int i = 0; i < N_MINMAX_RANDOM; i++) begin
            run_op(FP_CMD_MIN, rand_number(), rand_number());
            run_op(FP_CMD_MAX, rand_number(), rand_number());
        end
        run_op(FP_CMD_MIN, 32'h0000_0000, 32'h8000_0000);
        run_op(FP_CMD_MIN, 32'h8000_0000, 32'h0000_0000);
        run_op(FP_CMD_MAX, 32'h0000_0000, 32'h8000_0000);
        run_op(FP_CMD_MAX, 32'h8000_0000, 32'h0000_0000);
        run_op(FP_CMD_MIN, QNAN, ONE);
        run_op(FP_CMD_MAX, ONE, QNAN);
        run_op(FP_CMD_MIN, SNAN, ONE);
        run_op(FP_CMD_MAX, ONE, SNAN);
        run_op(FP_CMD_MIN, QNAN, QNAN);
        run_op(FP_CMD_MAX, QNAN, SNAN);
        run_op(FP_CMD_MIN, SNAN, SNAN);
        run_op(FP_CMD_MAX, SNAN, QNAN);
        finish_test("min/max");
    endtask

    task automatic test_classify();
        logic [31:0] ops[10] = '{32'hff80_0000, 32'hbf80_0000, 32'h8000_0001, 32'h8000_0000,
                                 32'h0000_0000, 32'h0000_0001, ONE, 32'h7f80_0000, SNAN, QNAN};
        for (int i = 0; i < 10; i++) run_op(FP_CMD_CLASS, ops[i], ONE);
        finish_test("classify");
    endtask

    initial begin
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_timing();
        test_ordering();
        test_nan_compare();
        test_min_max();
        test_classify();
        $display("Checks: %0d passed, %0d failed", checks - errors, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/fp_compare_unit.sv
// Fixed one-cycle latency, no back-pressure; results are held until the next op_valid
`timescale 1ns/1ps
`default_nettype none

module fp_compare_unit
    import fp_cmp_pkg::*;
#(
    parameter int EXPONENT_WIDTH = 8,
    parameter int FRACTION_WIDTH = 23,
    localparam int WIDTH = 1 + EXPONENT_WIDTH + FRACTION_WIDTH
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             op_valid,
    input  fp_cmd_t          cmd,
    input  logic [WIDTH-1:0] src1,
    input  logic [WIDTH-1:0] src2,
    output logic             res_valid,
    output word_t            int_result,
    output logic [WIDTH-1:0] fp_result,
    output fflags_t          fflags
);

    fclass_t          class1;
    fclass_t          class2;
    logic             cmp_int;
    logic [WIDTH-1:0] cmp_fp_result;
    logic             invalid;

    word_t            int_next;
    fflags_t          fflags_next;

    fp_classifier #(
        .EXPONENT_WIDTH (EXPONENT_WIDTH),
        .FRACTION_WIDTH (FRACTION_WIDTH)
    ) u_class1 (
        .operand (src1),
        .fclass  (class1)
    );

    fp_classifier #(
        .EXPONENT_WIDTH (EXPONENT_WIDTH),
        .FRACTION_WIDTH (FRACTION_WIDTH)
    ) u_class2 (
        .operand (src2),
        .fclass  (class2)
    );

    fp_comparator #(
        .EXPONENT_WIDTH (EXPONENT_WIDTH),
        .FRACTION_WIDTH (FRACTION_WIDTH)
    ) u_cmp (
        .cmd       (cmd),
        .src1      (src1),
        .src2      (src2),
        .class1    (class1),
        .class2    (class2),
        .cmp_int   (cmp_int),
        .fp_result (cmp_fp_result),
        .invalid   (invalid)
    );

    always_comb begin
        int_next = (cmd == FP_CMD_CLASS) ? word_t'(class1) : word_t'(cmp_int);  // Zero-extended
        fflags_next = '0;
        fflags_next[FFLAG_NV] = invalid;    // Only NV can be raised here
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid  <= 1'b0;
            int_result <= '0;
            fp_result  <= '0;
            fflags     <= '0;
        end else begin
            res_valid <= op_valid;
            if (op_valid) begin
                int_result <= int_next;
                fp_result  <= cmp_fp_result;
                fflags     <= fflags_next;
            end
        end
    end

    // First sampled edge with reset released still shows the cleared pipeline
    a_no_valid_after_reset: assert property (
        @(posedge clk) $rose(arst_n) |-> !res_valid
    ) else $error("res_valid high right after reset release");

    a_only_nv_flag: assert property (
        @(posedge clk) disable iff (!arst_n)
        res_valid |-> ((fflags & ~(fflags_t'(1) << FFLAG_NV)) == '0)
    ) else $error("fflags has bits other than NV set");

    // Classifiers must decode every operand into exactly one class
    a_class_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        op_valid |-> ($onehot(class1) && $onehot(class2))
    ) else $error("classifier mask not one-hot");

endmodule

`default_nettype wire

//--- rtl/fp_comparator.sv
// Combinational; expects class masks of the same operands, fp_result is only meaningful for fmin/fmax
`timescale 1ns/1ps
`default_nettype none

module fp_comparator
    import fp_cmp_pkg::*;
#(
    parameter int EXPONENT_WIDTH = 8,
    parameter int FRACTION_WIDTH = 23,
    localparam int WIDTH = 1 + EXPONENT_WIDTH + FRACTION_WIDTH
) (
    input  fp_cmd_t          cmd,
    input  logic [WIDTH-1:0] src1,
    input  logic [WIDTH-1:0] src2,
    input  fclass_t          class1,
    input  fclass_t          class2,
    output logic             cmp_int,
    output logic [WIDTH-1:0] fp_result,
    output logic             invalid
);

    // Exponent and fraction side by side order like an unsigned magnitude
    typedef logic [EXPONENT_WIDTH+FRACTION_WIDTH-1:0] mag_t;

    localparam logic [WIDTH-1:0] CANONICAL_QNAN =
        {1'b0, {EXPONENT_WIDTH{1'b1}}, 1'b1, {(FRACTION_WIDTH-1){1'b0}}};

    logic sign1;
    logic sign2;
    mag_t mag1;
    mag_t mag2;

    logic is_zero1;
    logic is_zero2;
    logic is_nan1;
    logic is_nan2;
    logic is_snan1;
    logic is_snan2;
    logic both_zero;
    logic any_nan;

    logic eq;
    logic lt;
    logic le;
    logic sel_lt;                       // lt with -0 below +0

    assign sign1 = src1[WIDTH-1];
    assign sign2 = src2[WIDTH-1];
    assign mag1  = src1[WIDTH-2:0];
    assign mag2  = src2[WIDTH-2:0];

    // Special values come from the classifiers
    assign is_zero1 = class1[CLASS_NEG_ZERO] | class1[CLASS_POS_ZERO];
    assign is_zero2 = class2[CLASS_NEG_ZERO] | class2[CLASS_POS_ZERO];
    assign is_snan1 = class1[CLASS_SNAN];
    assign is_snan2 = class2[CLASS_SNAN];
    assign is_nan1  = class1[CLASS_SNAN] | class1[CLASS_QNAN];
    assign is_nan2  = class2[CLASS_SNAN] | class2[CLASS_QNAN];

    assign both_zero = is_zero1 & is_zero2;
    assign any_nan   = is_nan1 | is_nan2;

    always_comb begin
        eq = (src1 == src2) | both_zero;
        if (both_zero) begin
            lt = 1'b0;                  // +0 and -0 compare equal
        end else if (sign1 != sign2) begin
            lt = sign1;
        end else if (!sign1) begin
            lt = (mag1 < mag2);
        end else begin
            lt = (mag1 > mag2);         // Both negative, larger magnitude is smaller
        end
        le = eq | lt;
        sel_lt = lt | (both_zero & sign1 & !sign2);
    end

    // Integer compare result, NaN forces zero
    always_comb begin
        cmp_int = 1'b0;
        if (!any_nan) begin
            case (cmd)
                FP_CMD_EQ: cmp_int = eq;
                FP_CMD_LT: cmp_int = lt;
                FP_CMD_LE: cmp_int = le;
                default:   cmp_int = 1'b0;
            endcase
        end
    end

    // Min/max selection
    always_comb begin
        fp_result = '0;
        if (cmd == FP_CMD_MIN || cmd == FP_CMD_MAX) begin
            if (is_nan1 && is_nan2) begin
                fp_result = CANONICAL_QNAN;
            end else if (is_nan1) begin
                fp_result = src2;
            end else if (is_nan2) begin
                fp_result = src1;
            end else if (cmd == FP_CMD_MIN) begin
                fp_result = sel_lt ? src1 : src2;
            end else begin
                fp_result = sel_lt ? src2 : src1;
            end
        end
    end

    // Signaling compares trap on any NaN, quiet ones only on sNaN
    always_comb begin
        case (cmd)
            FP_CMD_EQ,
            FP_CMD_MIN,
            FP_CMD_MAX: invalid = is_snan1 | is_snan2;
            FP_CMD_LT,
            FP_CMD_LE:  invalid = any_nan;
            default:    invalid = 1'b0;   // fclass never traps
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/fp_classifier.sv
// Purely combinational; a NaN with fraction MSB clear is signaling, and exactly one class bit is set
`timescale 1ns/1ps
`default_nettype none

module fp_classifier
    import fp_cmp_pkg::*;
#(
    parameter int EXPONENT_WIDTH = 8,
    parameter int FRACTION_WIDTH = 23,
    localparam int WIDTH = 1 + EXPONENT_WIDTH + FRACTION_WIDTH
) (
    input  logic [WIDTH-1:0] operand,
    output fclass_t          fclass
);

    typedef logic [EXPONENT_WIDTH-1:0] exp_t;
    typedef logic [FRACTION_WIDTH-1:0] frac_t;

    logic  sign;
    exp_t  exponent;
    frac_t fraction;

    logic exp_zero;
    logic exp_ones;
    logic frac_zero;

    assign sign     = operand[WIDTH-1];
    assign exponent = operand[WIDTH-2:FRACTION_WIDTH];
    assign fraction = operand[FRACTION_WIDTH-1:0];

    assign exp_zero  = (exponent == '0);
    assign exp_ones  = (exponent == '1);
    assign frac_zero = (fraction == '0);

    always_comb begin
        fclass = '0;
        if (exp_ones && !frac_zero) begin
            // Quiet bit is the fraction MSB
            if (fraction[FRACTION_WIDTH-1]) begin
                fclass[CLASS_QNAN] = 1'b1;
            end else begin
                fclass[CLASS_SNAN] = 1'b1;
            end
        end else if (exp_ones) begin
            if (sign) begin
                fclass[CLASS_NEG_INF] = 1'b1;
            end else begin
                fclass[CLASS_POS_INF] = 1'b1;
            end
        end else if (exp_zero && frac_zero) begin
            if (sign) begin
                fclass[CLASS_NEG_ZERO] = 1'b1;
            end else begin
                fclass[CLASS_POS_ZERO] = 1'b1;
            end
        end else if (exp_zero) begin
            if (sign) begin
                fclass[CLASS_NEG_SUB] = 1'b1;    // Denormal, no hidden bit
            end else begin
                fclass[CLASS_POS_SUB] = 1'b1;
            end
        end else begin
            if (sign) begin
                fclass[CLASS_NEG_NORM] = 1'b1;
            end else begin
                fclass[CLASS_POS_NORM] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/fp_cmp_pkg.sv
// Defines only compare and classify commands; class bit order and flag layout follow RISC-V F
`default_nettype none

package fp_cmp_pkg;

    // Integer result as written back to the integer register file
    typedef logic [31:0] word_t;

    // One-hot class mask, bit 0 is negative infinity
    typedef logic [9:0] fclass_t;

    // Exception flags in fcsr order
    typedef logic [4:0] fflags_t;         // NV DZ OF UF NX

    typedef enum logic [2:0] {
        FP_CMD_EQ    = 3'd0,              // feq
        FP_CMD_LT    = 3'd1,              // flt
        FP_CMD_LE    = 3'd2,              // fle
        FP_CMD_MIN   = 3'd3,              // fmin
        FP_CMD_MAX   = 3'd4,              // fmax
        FP_CMD_CLASS = 3'd5               // fclass
    } fp_cmd_t;

    // Bit positions inside fclass_t
    localparam int CLASS_NEG_INF  = 0;
    localparam int CLASS_NEG_NORM = 1;
    localparam int CLASS_NEG_SUB  = 2;
    localparam int CLASS_NEG_ZERO = 3;
    localparam int CLASS_POS_ZERO = 4;
    localparam int CLASS_POS_SUB  = 5;
    localparam int CLASS_POS_NORM = 6;
    localparam int CLASS_POS_INF  = 7;
    localparam int CLASS_SNAN     = 8;
    localparam int CLASS_QNAN     = 9;

    // Invalid operation flag
    localparam int FFLAG_NV = 4;

endpackage

`default_nettype wire
